// ==== flist.f ====
+incdir+logic
logic/rv32i_pkg.sv
logic/ooo_pkg.sv
logic/cmp_rs.sv
logic/cmp_unit.sv
logic/cmp_broadcast.sv
logic/cmp_top.sv
test/cmp_tb.sv

// ==== logic/cmp_broadcast.sv ====
`timescale 1ns/10ps
`include "cmp_defines.svh"

module cmp_broadcast (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  logic                cu_valid_i,
    input  rv32i_pkg::cmp_op_e  cu_op_i,
    input  ooo_pkg::rob_tag_t   cu_tag_i,
    input  logic                cu_flag_i,
    input  rv32i_pkg::word_t    cu_target_i,
    // cdb write
    output logic                res_valid_o,
    output ooo_pkg::rob_tag_t   res_tag_o,
    output rv32i_pkg::word_t    res_value_o,
    // branch redirect
    output logic                br_valid_o,
    output ooo_pkg::rob_tag_t   br_tag_o,
    output logic                br_taken_o,
    output rv32i_pkg::word_t    br_next_pc_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // slt class writes a register, everything else redirects
    logic is_slt;

    assign is_slt = (cu_op_i == CMP_SLT) || (cu_op_i == CMP_SLTU);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
            br_valid_o  <= 1'b0;
        end else begin
            res_valid_o <= cu_valid_i && is_slt && !flush_i;
            br_valid_o  <= cu_valid_i && !is_slt && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cu_valid_i) begin
            res_tag_o    <= cu_tag_i;
            res_value_o  <= {{(`XLEN-1){1'b0}}, cu_flag_i};
            br_tag_o     <= cu_tag_i;
            br_taken_o   <= cu_flag_i;
            br_next_pc_o <= cu_target_i;
        end
    end

    // one instruction leaves per cycle, on one path only
    a_one_path: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(res_valid_o && br_valid_o));

endmodule : cmp_broadcast

// ==== logic/cmp_defines.svh ====
`ifndef CMP_DEFINES_SVH
`define CMP_DEFINES_SVH

// sizes shared by the compare path

// architectural data width, rv32i
`define XLEN 32

// reorder buffer tag width
// 16 in-flight instructions
`define ROB_TAG_W 4

// compare reservation station depth
`define CMP_RS_ENTRIES 4

`endif

// ==== logic/cmp_rs.sv ====
`timescale 1ns/10ps
`include "cmp_defines.svh"

module cmp_rs (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    // dispatch from decoder
    input  logic                disp_valid_i,
    input  rv32i_pkg::cmp_op_e  disp_op_i,
    input  ooo_pkg::rob_tag_t   disp_tag_i,
    input  logic                disp_rs1_rdy_i,
    input  rv32i_pkg::word_t    disp_rs1_val_i,
    input  ooo_pkg::rob_tag_t   disp_rs1_tag_i,
    input  logic                disp_rs2_rdy_i,
    input  rv32i_pkg::word_t    disp_rs2_val_i,
    input  ooo_pkg::rob_tag_t   disp_rs2_tag_i,
    input  rv32i_pkg::word_t    disp_pc_i,
    input  rv32i_pkg::word_t    disp_imm_i,
    // external cdb
    input  logic                cdb_valid_i,
    input  ooo_pkg::rob_tag_t   cdb_tag_i,
    input  rv32i_pkg::word_t    cdb_value_i,
    // own result, looped back
    input  logic                fwd_valid_i,
    input  ooo_pkg::rob_tag_t   fwd_tag_i,
    input  rv32i_pkg::word_t    fwd_value_i,
    // to decoder / comparator
    output logic                rs_full_o,
    output logic                iss_valid_o,
    output rv32i_pkg::cmp_op_e  iss_op_o,
    output ooo_pkg::rob_tag_t   iss_tag_o,
    output rv32i_pkg::word_t    iss_a_o,
    output rv32i_pkg::word_t    iss_b_o,
    output rv32i_pkg::word_t    iss_pc_o,
    output rv32i_pkg::word_t    iss_imm_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // slot control
    logic [`CMP_RS_ENTRIES-1:0] busy_q;
    logic [`CMP_RS_ENTRIES-1:0] rdy1_q;
    logic [`CMP_RS_ENTRIES-1:0] rdy2_q;
    // slot payload
    cmp_op_e  op_q   [`CMP_RS_ENTRIES];
    rob_tag_t tag_q  [`CMP_RS_ENTRIES];
    word_t    pc_q   [`CMP_RS_ENTRIES];
    word_t    imm_q  [`CMP_RS_ENTRIES];
    word_t    val1_q [`CMP_RS_ENTRIES];
    word_t    val2_q [`CMP_RS_ENTRIES];
    rob_tag_t src1_q [`CMP_RS_ENTRIES];
    rob_tag_t src2_q [`CMP_RS_ENTRIES];

    // operand state after this cycle's snoop
    logic [`CMP_RS_ENTRIES-1:0] nrdy1;
    logic [`CMP_RS_ENTRIES-1:0] nrdy2;
    word_t    nval1 [`CMP_RS_ENTRIES];
    word_t    nval2 [`CMP_RS_ENTRIES];
    logic     drdy1;
    logic     drdy2;
    word_t    dval1;
    word_t    dval2;

    logic [`CMP_RS_ENTRIES-1:0] ready_vec;
    logic [`CMP_RS_ENTRIES-1:0] sel_oh;
    rs_slot_t sel_idx;
    rs_slot_t free_idx;
    logic     disp_take;

    // capture a waiting operand from either bus
    // unique tags mean at most one bus hits
    function automatic logic [`XLEN:0] snoop(input logic rdy, input word_t val,
                                             input rob_tag_t src);
        if (rdy)
            return {1'b1, val};
        if (cdb_valid_i && cdb_tag_i == src)
            return {1'b1, cdb_value_i};
        if (fwd_valid_i && fwd_tag_i == src)
            return {1'b1, fwd_value_i};
        return {1'b0, val};
    endfunction

    always_comb begin
        for (int i = 0; i < `CMP_RS_ENTRIES; i++) begin
            {nrdy1[i], nval1[i]} = snoop(rdy1_q[i], val1_q[i], src1_q[i]);
            {nrdy2[i], nval2[i]} = snoop(rdy2_q[i], val2_q[i], src2_q[i]);
        end
        // bypass for operands arriving this cycle
        {drdy1, dval1} = snoop(disp_rs1_rdy_i, disp_rs1_val_i, disp_rs1_tag_i);
        {drdy2, dval2} = snoop(disp_rs2_rdy_i, disp_rs2_val_i, disp_rs2_tag_i);
    end

    // lowest free slot and lowest ready slot
    // descending scan so the lowest index wins
    always_comb begin
        ready_vec = busy_q & rdy1_q & rdy2_q;
        sel_oh    = '0;
        sel_idx   = '0;
        free_idx  = '0;
        for (int i = `CMP_RS_ENTRIES-1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_oh    = '0;
                sel_oh[i] = 1'b1;
                sel_idx   = rs_slot_t'(i);
            end
            if (!busy_q[i])
                free_idx = rs_slot_t'(i);
        end
    end

    assign rs_full_o = &busy_q;
    assign disp_take = disp_valid_i && !rs_full_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= '0;
            rdy1_q      <= '0;
            rdy2_q      <= '0;
            iss_valid_o <= 1'b0;
        end else if (flush_i) begin
            busy_q      <= '0;
            iss_valid_o <= 1'b0;
        end else begin
            rdy1_q <= nrdy1;
            rdy2_q <= nrdy2;
            // issued slot frees at this edge
            if (|sel_oh)
                busy_q[sel_idx] <= 1'b0;
            // free slot is never the issued one since that is still busy
            if (disp_take) begin
                busy_q[free_idx] <= 1'b1;
                rdy1_q[free_idx] <= drdy1;
                rdy2_q[free_idx] <= drdy2;
            end
            iss_valid_o <= |sel_oh;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CMP_RS_ENTRIES; i++) begin
            val1_q[i] <= nval1[i];
            val2_q[i] <= nval2[i];
        end
        if (disp_take) begin
            op_q[free_idx]   <= disp_op_i;
            tag_q[free_idx]  <= disp_tag_i;
            pc_q[free_idx]   <= disp_pc_i;
            imm_q[free_idx]  <= disp_imm_i;
            src1_q[free_idx] <= disp_rs1_tag_i;
            src2_q[free_idx] <= disp_rs2_tag_i;
            val1_q[free_idx] <= dval1;
            val2_q[free_idx] <= dval2;
        end
        // issue register onto the comparator
        if (|sel_oh) begin
            iss_op_o  <= op_q[sel_idx];
            iss_tag_o <= tag_q[sel_idx];
            iss_a_o   <= val1_q[sel_idx];
            iss_b_o   <= val2_q[sel_idx];
            iss_pc_o  <= pc_q[sel_idx];
            iss_imm_o <= imm_q[sel_idx];
        end
    end

    // decoder must stall on full
    a_no_disp_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        disp_valid_i |-> !rs_full_o);

    // at most one slot frees per edge and only one that was ready to issue
    a_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        !flush_i |=> $onehot0($past(busy_q) & ~busy_q)
            && (($past(busy_q) & ~busy_q & ~$past(ready_vec)) == '0));

endmodule : cmp_rs

// ==== logic/cmp_top.sv ====
`timescale 1ns/10ps
`include "cmp_defines.svh"

module cmp_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  logic                disp_valid_i,
    input  rv32i_pkg::cmp_op_e  disp_op_i,
    input  ooo_pkg::rob_tag_t   disp_tag_i,
    input  logic                disp_rs1_rdy_i,
    input  rv32i_pkg::word_t    disp_rs1_val_i,
    input  ooo_pkg::rob_tag_t   disp_rs1_tag_i,
    input  logic                disp_rs2_rdy_i,
    input  rv32i_pkg::word_t    disp_rs2_val_i,
    input  ooo_pkg::rob_tag_t   disp_rs2_tag_i,
    input  rv32i_pkg::word_t    disp_pc_i,
    input  rv32i_pkg::word_t    disp_imm_i,
    input  logic                cdb_valid_i,
    input  ooo_pkg::rob_tag_t   cdb_tag_i,
    input  rv32i_pkg::word_t    cdb_value_i,
    output logic                res_valid_o,
    output ooo_pkg::rob_tag_t   res_tag_o,
    output rv32i_pkg::word_t    res_value_o,
    output logic                br_valid_o,
    output ooo_pkg::rob_tag_t   br_tag_o,
    output logic                br_taken_o,
    output rv32i_pkg::word_t    br_next_pc_o,
    output logic                rs_full_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    // station to comparator
    logic     iss_valid;
    cmp_op_e  iss_op;
    rob_tag_t iss_tag;
    word_t    iss_a;
    word_t    iss_b;
    word_t    iss_pc;
    word_t    iss_imm;
    // comparator to result stage
    logic     cu_valid;
    cmp_op_e  cu_op;
    rob_tag_t cu_tag;
    logic     cu_flag;
    word_t    cu_target;

    // fwd port takes our own cdb write so slt results wake dependents
    cmp_rs u_rs (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (disp_valid_i),
        .disp_op_i      (disp_op_i),
        .disp_tag_i     (disp_tag_i),
        .disp_rs1_rdy_i (disp_rs1_rdy_i),
        .disp_rs1_val_i (disp_rs1_val_i),
        .disp_rs1_tag_i (disp_rs1_tag_i),
        .disp_rs2_rdy_i (disp_rs2_rdy_i),
        .disp_rs2_val_i (disp_rs2_val_i),
        .disp_rs2_tag_i (disp_rs2_tag_i),
        .disp_pc_i      (disp_pc_i),
        .disp_imm_i     (disp_imm_i),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .cdb_value_i    (cdb_value_i),
        .fwd_valid_i    (res_valid_o),
        .fwd_tag_i      (res_tag_o),
        .fwd_value_i    (res_value_o),
        .rs_full_o      (rs_full_o),
        .iss_valid_o    (iss_valid),
        .iss_op_o       (iss_op),
        .iss_tag_o      (iss_tag),
        .iss_a_o        (iss_a),
        .iss_b_o        (iss_b),
        .iss_pc_o       (iss_pc),
        .iss_imm_o      (iss_imm)
    );

    cmp_unit u_cu (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .iss_valid_i (iss_valid),
        .iss_op_i    (iss_op),
        .iss_tag_i   (iss_tag),
        .iss_a_i     (iss_a),
        .iss_b_i     (iss_b),
        .iss_pc_i    (iss_pc),
        .iss_imm_i   (iss_imm),
        .cu_valid_o  (cu_valid),
        .cu_op_o     (cu_op),
        .cu_tag_o    (cu_tag),
        .cu_flag_o   (cu_flag),
        .cu_target_o (cu_target)
    );

    cmp_broadcast u_bc (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .cu_valid_i   (cu_valid),
        .cu_op_i      (cu_op),
        .cu_tag_i     (cu_tag),
        .cu_flag_i    (cu_flag),
        .cu_target_i  (cu_target),
        .res_valid_o  (res_valid_o),
        .res_tag_o    (res_tag_o),
        .res_value_o  (res_value_o),
        .br_valid_o   (br_valid_o),
        .br_tag_o     (br_tag_o),
        .br_taken_o   (br_taken_o),
        .br_next_pc_o (br_next_pc_o)
    );

endmodule : cmp_top

// ==== logic/cmp_unit.sv ====
`timescale 1ns/10ps
`include "cmp_defines.svh"

module cmp_unit (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  logic                iss_valid_i,
    input  rv32i_pkg::cmp_op_e  iss_op_i,
    input  ooo_pkg::rob_tag_t   iss_tag_i,
    input  rv32i_pkg::word_t    iss_a_i,
    input  rv32i_pkg::word_t    iss_b_i,
    input  rv32i_pkg::word_t    iss_pc_i,
    input  rv32i_pkg::word_t    iss_imm_i,
    output logic                cu_valid_o,
    output rv32i_pkg::cmp_op_e  cu_op_o,
    output ooo_pkg::rob_tag_t   cu_tag_o,
    output logic                cu_flag_o,
    output rv32i_pkg::word_t    cu_target_o
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic  flag_d;
    word_t target_d;

    always_comb begin
        case (iss_op_i)
            CMP_BEQ:           flag_d = (iss_a_i == iss_b_i);
            CMP_BNE:           flag_d = (iss_a_i != iss_b_i);
            CMP_BLT, CMP_SLT:  flag_d = ($signed(iss_a_i) < $signed(iss_b_i));
            CMP_BGE:           flag_d = ($signed(iss_a_i) >= $signed(iss_b_i));
            CMP_BLTU, CMP_SLTU: flag_d = (iss_a_i < iss_b_i);
            CMP_BGEU:          flag_d = (iss_a_i >= iss_b_i);
            default:           flag_d = 1'b0;
        endcase
        // next pc is only consumed by branches
        target_d = flag_d ? (iss_pc_i + iss_imm_i) : (iss_pc_i + word_t'(4));
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            cu_valid_o <= 1'b0;
        else
            cu_valid_o <= iss_valid_i && !flush_i;
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i) begin
            cu_op_o     <= iss_op_i;
            cu_tag_o    <= iss_tag_i;
            cu_flag_o   <= flag_d;
            cu_target_o <= target_d;
        end
    end

    // opcode travelling with a valid result is a known encoding
    a_op_legal: assert property (@(posedge clk) disable iff (!arst_n_i)
        cu_valid_o |-> (!$isunknown(cu_op_o) && cu_op_o inside {CMP_BEQ, CMP_BNE, CMP_BLT,
            CMP_BGE, CMP_BLTU, CMP_BGEU, CMP_SLT, CMP_SLTU}));

endmodule : cmp_unit

// ==== logic/ooo_pkg.sv ====
`include "cmp_defines.svh"

// types of the out-of-order machinery
package ooo_pkg;

    // rob entry tag, unique while in flight
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // index into the compare reservation station
    typedef logic [$clog2(`CMP_RS_ENTRIES)-1:0] rs_slot_t;

endpackage : ooo_pkg

// ==== logic/rv32i_pkg.sv ====
`include "cmp_defines.svh"

// isa-level types seen by the compare path
package rv32i_pkg;

    // operand / result / pc word
    typedef logic [`XLEN-1:0] word_t;

    // compare opcodes after decode
    // slti and sltiu fold into slt / sltu
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'd0,
        CMP_BNE  = 3'd1,
        CMP_BLT  = 3'd2,
        CMP_BGE  = 3'd3,
        CMP_BLTU = 3'd4,
        CMP_BGEU = 3'd5,
        CMP_SLT  = 3'd6,
        CMP_SLTU = 3'd7
    } cmp_op_e;

endpackage : rv32i_pkg

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the compare path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module cmp_tb -f flist.f -o sim

# the run may stop on a failure, the log decides the outcome
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

grep -q -F "*** PASSED ***" sim.log
echo "simulation passed"

// ==== test/cmp_tb.sv ====
`timescale 1ns/10ps

module cmp_tb;
    import rv32i_pkg::*;
    import ooo_pkg::*;

    localparam int DIRECTED_OPS = 48;
    localparam int RANDOM_OPS   = 300;
    localparam int WDOG_CYCLES  = (DIRECTED_OPS + RANDOM_OPS) * 20 + 200;

    logic     clk;
    logic     arst_n_i;
    logic     flush_i;
    logic     disp_valid_i;
    cmp_op_e  disp_op_i;
    rob_tag_t disp_tag_i;
    logic     disp_rs1_rdy_i;
    word_t    disp_rs1_val_i;
    rob_tag_t disp_rs1_tag_i;
    logic     disp_rs2_rdy_i;
    word_t    disp_rs2_val_i;
    rob_tag_t disp_rs2_tag_i;
    word_t    disp_pc_i;
    word_t    disp_imm_i;
    logic     cdb_valid_i;
    rob_tag_t cdb_tag_i;
    word_t    cdb_value_i;
    logic     res_valid_o;
    rob_tag_t res_tag_o;
    word_t    res_value_o;
    logic     br_valid_o;
    rob_tag_t br_tag_o;
    logic     br_taken_o;
    word_t    br_next_pc_o;
    logic     rs_full_o;

    // scoreboard indexed by rob tag
    logic     exp_pending [16];
    logic     exp_is_br   [16];
    logic     exp_flag    [16];
    word_t    exp_pc      [16];
    int       outstanding;
    int       next_tag;
    // external producers use tags 8..15 and compare ops use 0..7
    word_t    ext_val [16];
    int       ext_q[$];
    logic     disp_done;
    logic [31:0] rng_state;

    cmp_top u_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // flag in the top bit and next pc below
    function automatic logic [32:0] cmp_model(cmp_op_e op, word_t a, word_t b, word_t pc,
                                              word_t imm);
        logic  eq;
        logic  ltu;
        logic  lts;
        logic  flag;
        eq  = (a == b);
        ltu = (a < b);
        // with differing signs the negative one is smaller
        lts = (a[$bits(word_t)-1] != b[$bits(word_t)-1]) ? a[$bits(word_t)-1] : ltu;
        case (op)
            CMP_BEQ:            flag = eq;
            CMP_BNE:            flag = !eq;
            CMP_BLT, CMP_SLT:   flag = lts;
            CMP_BGE:            flag = !lts;
            CMP_BLTU, CMP_SLTU: flag = ltu;
            default:            flag = !ltu;
        endcase
        return {flag, flag ? pc + imm : pc + 32'd4};
    endfunction

    task automatic report_error(string msg);
        $display("error: t=%0t %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic retire(rob_tag_t tag);
        exp_pending[tag] = 1'b0;
        outstanding--;
    endtask

    task automatic check_result(rob_tag_t tag, word_t value);
        if (!exp_pending[tag] || exp_is_br[tag])
            report_error($sformatf("unexpected cdb write, tag %0d", tag));
        if (value !== word_t'(exp_flag[tag]))
            report_error($sformatf("tag %0d value %h, expected %h", tag, value,
                                   word_t'(exp_flag[tag])));
        retire(tag);
    endtask

    task automatic check_branch(rob_tag_t tag, logic taken, word_t next_pc);
        if (!exp_pending[tag] || !exp_is_br[tag])
            report_error($sformatf("unexpected redirect, tag %0d", tag));
        if (taken !== exp_flag[tag] || next_pc !== exp_pc[tag])
            report_error($sformatf("tag %0d taken %b pc %h, expected %b %h", tag, taken,
                                   next_pc, exp_flag[tag], exp_pc[tag]));
        retire(tag);
    endtask

    // registered outputs are sampled away from the rising edge
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (res_valid_o && br_valid_o)
                report_error("cdb write and redirect in the same cycle");
            if (res_valid_o)
                check_result(res_tag_o, res_value_o);
            if (br_valid_o)
                check_branch(br_tag_o, br_taken_o, br_next_pc_o);
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: results did not complete within %0d cycles", WDOG_CYCLES);
        $display("*** FAILED ***");
        $fatal(1);
    end

    // wait for room in the station and a free tag at the falling edge
    task automatic wait_slot(output rob_tag_t tag);
        logic found;
        found = 1'b0;
        do begin
            @(negedge clk);
            for (int k = 0; k < 8 && !found; k++) begin
                if (!exp_pending[(next_tag + k) % 8]) begin
                    tag      = rob_tag_t'((next_tag + k) % 8);
                    found    = 1'b1;
                    next_tag = (next_tag + k + 1) % 8;
                end
            end
        end while (rs_full_o || !found);
    endtask

    task automatic drive_dispatch(cmp_op_e op, rob_tag_t tag, logic r1, rob_tag_t t1,
                                  word_t a, logic r2, rob_tag_t t2, word_t b,
                                  logic with_cdb, rob_tag_t ctag, word_t cval);
        word_t pc;
        word_t imm;
        pc  = xorshift() & 32'hffff_fffc;
        imm = xorshift() & 32'h0000_1ffe;
        exp_pending[tag] = 1'b1;
        exp_is_br[tag]   = !(op inside {CMP_SLT, CMP_SLTU});
        {exp_flag[tag], exp_pc[tag]} = cmp_model(op, a, b, pc, imm);
        outstanding++;
        @(posedge clk);
        disp_valid_i   <= 1'b1;
        disp_op_i      <= op;
        disp_tag_i     <= tag;
        disp_rs1_rdy_i <= r1;
        disp_rs1_tag_i <= t1;
        // a waiting operand carries junk
        disp_rs1_val_i <= r1 ? a : xorshift();
        disp_rs2_rdy_i <= r2;
        disp_rs2_tag_i <= t2;
        disp_rs2_val_i <= r2 ? b : xorshift();
        disp_pc_i      <= pc;
        disp_imm_i     <= imm;
        if (with_cdb) begin
            cdb_valid_i <= 1'b1;
            cdb_tag_i   <= ctag;
            cdb_value_i <= cval;
        end
        @(posedge clk);
        disp_valid_i <= 1'b0;
        if (with_cdb)
            cdb_valid_i <= 1'b0;
    endtask

    task automatic dispatch_op(cmp_op_e op, logic r1, rob_tag_t t1, word_t a, logic r2,
                               rob_tag_t t2, word_t b, output rob_tag_t tag);
        wait_slot(tag);
        drive_dispatch(op, tag, r1, t1, a, r2, t2, b, 1'b0, '0, '0);
    endtask

    task automatic broadcast(rob_tag_t tag, word_t value);
        @(posedge clk);
        cdb_valid_i <= 1'b1;
        cdb_tag_i   <= tag;
        cdb_value_i <= value;
        @(posedge clk);
        cdb_valid_i <= 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0)
            @(negedge clk);
    endtask

    // random mix operand is ready or waits on an external producer
    task automatic pick_operand(output logic rdy, output rob_tag_t src, output word_t val);
        int p;
        rdy = xorshift() % 2;
        val = xorshift();
        src = rob_tag_t'(8 + xorshift() % 8);
        if (!rdy) begin
            if (ext_q.size() > 0 && xorshift() % 2) begin
                p = ext_q[xorshift() % ext_q.size()];
            end else begin
                p = 8 + xorshift() % 8;
                for (int k = 0; k < 8 && (p inside {ext_q}); k++)
                    p = 8 + (p - 8 + 1) % 8;
                if (!(p inside {ext_q})) begin
                    ext_val[p] = xorshift();
                    ext_q.push_back(p);
                end
            end
            src = rob_tag_t'(p);
            val = ext_val[p];
        end
    endtask

    initial begin
        rob_tag_t t0;
        rob_tag_t t1;
        rob_tag_t t2;
        rob_tag_t tag;
        word_t    a;
        word_t    b;
        logic     r1;
        logic     r2;
        rob_tag_t s1;
        rob_tag_t s2;
        logic [32:0] m;

        clk = 1'b0;
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = 1'b0;
        disp_op_i = CMP_BEQ;
        disp_tag_i = '0;
        disp_rs1_rdy_i = 1'b0;
        disp_rs1_val_i = '0;
        disp_rs1_tag_i = '0;
        disp_rs2_rdy_i = 1'b0;
        disp_rs2_val_i = '0;
        disp_rs2_tag_i = '0;
        disp_pc_i = '0;
        disp_imm_i = '0;
        cdb_valid_i = 1'b0;
        cdb_tag_i = '0;
        cdb_value_i = '0;
        rng_state = 32'd28930;
        outstanding = 0;
        next_tag = 0;
        disp_done = 1'b0;
        for (int k = 0; k < 16; k++)
            exp_pending[k] = 1'b0;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;

        // every opcode with boundary and random operands
        for (int k = 0; k < 8; k++) begin
            for (int v = 0; v < 4; v++) begin
                a = xorshift();
                case (v)
                    0: b = a;
                    1: begin a = 32'h8000_0000; b = 32'h0000_0001; end
                    2: begin a = 32'hffff_ffff; b = 32'h0000_0000; end
                    default: b = xorshift();
                endcase
                dispatch_op(cmp_op_e'(k), 1'b1, '0, a, 1'b1, '0, b, tag);
            end
        end
        drain();

        // wakeup from the external cdb in either operand and in the dispatch cycle
        dispatch_op(CMP_BLT, 1'b0, 4'd8, 32'hffff_fff0, 1'b1, '0, 32'd3, tag);
        dispatch_op(CMP_SLTU, 1'b1, '0, 32'd7, 1'b0, 4'd10, 32'd9, tag);
        broadcast(4'd8, 32'hffff_fff0);
        broadcast(4'd10, 32'd9);
        wait_slot(tag);
        drive_dispatch(CMP_BGEU, tag, 1'b0, 4'd11, 32'h1234, 1'b1, '0, 32'h1000,
                       1'b1, 4'd11, 32'h1234);
        drain();

        // slt result feeding later compares through the self wakeup
        a = xorshift();
        b = xorshift();
        dispatch_op(CMP_SLT, 1'b1, '0, a, 1'b1, '0, b, t0);
        m = cmp_model(CMP_SLT, a, b, '0, '0);
        dispatch_op(CMP_BEQ, 1'b0, t0, word_t'(m[32]), 1'b1, '0, 32'd1, tag);
        dispatch_op(CMP_SLTU, 1'b1, '0, 32'd0, 1'b1, '0, 32'd5, t1);
        dispatch_op(CMP_SLT, 1'b1, '0, 32'd0, 1'b0, t1, 32'd1, tag);
        drain();

        // fill the station and let a single wakeup drain it
        dispatch_op(CMP_BNE, 1'b0, 4'd9, 32'h55, 1'b1, '0, 32'h55, tag);
        dispatch_op(CMP_SLT, 1'b1, '0, 32'h56, 1'b0, 4'd9, 32'h55, tag);
        dispatch_op(CMP_BGE, 1'b0, 4'd9, 32'h55, 1'b1, '0, 32'h80000000, tag);
        dispatch_op(CMP_BLTU, 1'b0, 4'd9, 32'h55, 1'b0, 4'd9, 32'h55, tag);
        @(negedge clk);
        if (!rs_full_o)
            report_error("station not full after four waiting dispatches");
        broadcast(4'd9, 32'h55);
        while (rs_full_o)
            @(negedge clk);
        drain();

        // waiting entries and the compare in flight never complete
        dispatch_op(CMP_BEQ, 1'b0, 4'd13, 32'd1, 1'b1, '0, 32'd1, t0);
        dispatch_op(CMP_SLT, 1'b1, '0, 32'd1, 1'b0, 4'd13, 32'd1, t1);
        // issues at the next edge and sits in the comparator input at the flush
        dispatch_op(CMP_BNE, 1'b1, '0, 32'd2, 1'b1, '0, 32'd3, t2);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        retire(t0);
        retire(t1);
        retire(t2);
        broadcast(4'd13, 32'd1);
        repeat (10) @(negedge clk);
        // later dispatches complete
        dispatch_op(CMP_BGE, 1'b1, '0, 32'd4, 1'b1, '0, 32'd4, tag);
        dispatch_op(CMP_SLTU, 1'b0, 4'd14, 32'd2, 1'b1, '0, 32'd4, tag);
        broadcast(4'd14, 32'd2);
        drain();

        // random mix with a concurrent cdb driver
        fork
            begin
                for (int n = 0; n < RANDOM_OPS; n++) begin
                    wait_slot(tag);
                    pick_operand(r1, s1, a);
                    pick_operand(r2, s2, b);
                    drive_dispatch(cmp_op_e'(xorshift() % 8), tag, r1, s1, a, r2, s2, b,
                                   1'b0, '0, '0);
                end
                disp_done = 1'b1;
            end
            begin
                while (!disp_done || ext_q.size() > 0) begin
                    int idx;
                    @(posedge clk);
                    if (ext_q.size() > 0 && xorshift() % 3 == 0) begin
                        idx = xorshift() % ext_q.size();
                        cdb_valid_i <= 1'b1;
                        cdb_tag_i   <= rob_tag_t'(ext_q[idx]);
                        cdb_value_i <= ext_val[ext_q[idx]];
                        ext_q.delete(idx);
                    end else begin
                        cdb_valid_i <= 1'b0;
                    end
                end
                @(posedge clk);
                cdb_valid_i <= 1'b0;
            end
        join
        drain();
        repeat (5) @(negedge clk);

        if (outstanding != 0) begin
            $display("scoreboard still holds %0d results at the end", outstanding);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule : cmp_tb
